/* hw/tcb_pkg.sv */
////////////////////////////////////////
// TCB byte-lane memory shared defs
// default bus widths and clear states
////////////////////////////////////////

package tcb_pkg;

  ////////////////////////////////////////
  // bus defaults
  ////////////////////////////////////////

  // byte address width
  localparam int unsigned TCB_ADR_DEF = 10;
  // bus data width, one word
  localparam int unsigned TCB_DAT_DEF = 32;

  // width of one byte lane
  localparam int unsigned TCB_BYTE = 8;

  ////////////////////////////////////////
  // clear sequencer
  ////////////////////////////////////////

  // clear sweep after reset, then normal run
  typedef enum logic {
    ST_CLEAR = 1'b0,
    ST_RUN   = 1'b1
  } tcb_clr_state_t;

endpackage: tcb_pkg

/* hw/tcb_mem_clear_fsm.sv */
////////////////////////////////////////
// post-reset clear state machine
// holds the bus off until memory is zero
////////////////////////////////////////

`timescale 1ns/100ps

module tcb_mem_clear_fsm
  import tcb_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  // last word of the sweep
  input  logic clr_last,
  // clear in progress
  output logic clr_act,
  // bus ready
  output logic rdy
);

  tcb_clr_state_t state;

  // sweep runs once, then stays in run for good
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_CLEAR;
      rdy   <= 1'b0;
    end else if (state == ST_CLEAR && clr_last) begin
      state <= ST_RUN;
      rdy   <= 1'b1;
    end
  end

  // counter enable and controller source select
  assign clr_act = (state == ST_CLEAR);

  // bus must stay blocked for the whole sweep
  a_rdy_in_clear: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == ST_CLEAR) |-> !rdy
  );

endmodule: tcb_mem_clear_fsm

/* hw/tcb_mem_clear_counter.sv */
////////////////////////////////////////
// clear sweep word address counter
////////////////////////////////////////

`timescale 1ns/100ps

module tcb_mem_clear_counter
  import tcb_pkg::*;
#(
  parameter int unsigned ADR_W = TCB_ADR_DEF,
  parameter int unsigned DAT_W = TCB_DAT_DEF
)(
  input  logic clk,
  input  logic rst_n,
  // count enable
  input  logic clr_act,
  // word address being cleared
  output logic [ADR_W-$clog2(DAT_W/TCB_BYTE)-1:0] clr_adr,
  // final word flag
  output logic clr_last
);

  // lane and word geometry
  localparam int unsigned BEN   = DAT_W/TCB_BYTE;
  localparam int unsigned MEM_A = ADR_W-$clog2(BEN);
  localparam int unsigned WORDS = 2**MEM_A;

  // one word per cycle while clearing
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clr_adr <= '0;
    end else if (clr_act) begin
      clr_adr <= clr_adr + 1'b1;
    end
  end

  // top word reached during the sweep
  assign clr_last = clr_act && (clr_adr == MEM_A'(WORDS-1));

  // counter frozen outside the sweep
  a_adr_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    !clr_act |=> $stable(clr_adr)
  );

endmodule: tcb_mem_clear_counter

/* hw/tcb_lib_misaligned_memory_controller.sv */
////////////////////////////////////////
// misaligned access lane controller
// per-lane enables, addresses and data
////////////////////////////////////////

`timescale 1ns/100ps

module tcb_lib_misaligned_memory_controller
  import tcb_pkg::*;
#(
  parameter int unsigned ADR_W = TCB_ADR_DEF,
  parameter int unsigned DAT_W = TCB_DAT_DEF
)(
  input  logic clk,
  input  logic rst_n,
  // bus request
  input  logic                        vld,
  input  logic                        wen,
  input  logic [ADR_W-1:0]            adr,
  input  logic [DAT_W/TCB_BYTE-1:0]   ben,
  input  logic [DAT_W-1:0]            wdt,
  // clear sweep source
  input  logic                        clr_act,
  input  logic [ADR_W-$clog2(DAT_W/TCB_BYTE)-1:0] clr_adr,
  // lane SRAM side
  output logic [DAT_W/TCB_BYTE-1:0]   mem_cen,
  output logic                        mem_wen,
  output logic [DAT_W/TCB_BYTE-1:0][ADR_W-$clog2(DAT_W/TCB_BYTE)-1:0] mem_adr,
  output logic [DAT_W/TCB_BYTE-1:0][TCB_BYTE-1:0] mem_wdt,
  input  logic [DAT_W/TCB_BYTE-1:0][TCB_BYTE-1:0] mem_rdt,
  // bus response
  output logic                        rsp_vld,
  output logic [DAT_W-1:0]            rdt
);

  // lane geometry
  localparam int unsigned BEN   = DAT_W/TCB_BYTE;
  localparam int unsigned OFF_W = $clog2(BEN);
  localparam int unsigned MEM_A = ADR_W-OFF_W;

  ////////////////////////////////////////
  // address split
  ////////////////////////////////////////

  // word address and its successor
  logic [MEM_A-1:0] wrd;
  logic [MEM_A-1:0] nxt;
  // byte offset inside the word
  logic [OFF_W-1:0] off;
  // read accepted this cycle
  logic             rd_hsk;

  assign wrd = adr[OFF_W+:MEM_A];
  assign off = adr[OFF_W-1:0];
  // wraps to word zero at the top
  assign nxt = wrd + 1'b1;

  ////////////////////////////////////////
  // lane muxes
  ////////////////////////////////////////

  // clear sweep writes zero to every lane
  assign mem_cen = clr_act ? {BEN{1'b1}} : ({BEN{vld}} & ben);
  assign mem_wen = clr_act | wen;

  for (genvar i = 0; i < BEN; i++) begin: g_lane
    // lanes below the offset belong to the next word
    always_comb begin
      if (clr_act) begin
        mem_adr[i] = clr_adr;
      end else if (i < off) begin
        mem_adr[i] = nxt;
      end else begin
        mem_adr[i] = wrd;
      end
    end
    // lane i carries byte i of the bus
    assign mem_wdt[i] = clr_act ? '0 : wdt[i*TCB_BYTE+:TCB_BYTE];
  end

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  // bus is ready whenever the sweep is over
  assign rd_hsk = vld && !wen && !clr_act;

  // SRAM read latency is one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= rd_hsk;
    end
  end

  assign rdt = mem_rdt;

  // no response without a read the cycle before
  a_rsp_after_read: assert property (
    @(posedge clk) disable iff (!rst_n)
    rsp_vld |-> $past(vld && !wen && !clr_act)
  );

endmodule: tcb_lib_misaligned_memory_controller

/* hw/tcb_mem_bank.sv */
////////////////////////////////////////
// byte-lane SRAM banks
////////////////////////////////////////

`timescale 1ns/100ps

module tcb_mem_bank
  import tcb_pkg::*;
#(
  parameter int unsigned ADR_W = TCB_ADR_DEF,
  parameter int unsigned DAT_W = TCB_DAT_DEF
)(
  input  logic clk,
  // per-lane SRAM controls
  input  logic [DAT_W/TCB_BYTE-1:0]   mem_cen,
  input  logic                        mem_wen,
  input  logic [DAT_W/TCB_BYTE-1:0][ADR_W-$clog2(DAT_W/TCB_BYTE)-1:0] mem_adr,
  input  logic [DAT_W/TCB_BYTE-1:0][TCB_BYTE-1:0] mem_wdt,
  output logic [DAT_W/TCB_BYTE-1:0][TCB_BYTE-1:0] mem_rdt
);

  // lane and word geometry
  localparam int unsigned BEN   = DAT_W/TCB_BYTE;
  localparam int unsigned MEM_A = ADR_W-$clog2(BEN);
  localparam int unsigned WORDS = 2**MEM_A;

  for (genvar i = 0; i < BEN; i++) begin: g_bank
    // one byte wide array per lane
    logic [TCB_BYTE-1:0] mem [WORDS];
    // registered lane read byte
    logic [TCB_BYTE-1:0] rdt_q;

    // write or read, never both in a cycle
    always_ff @(posedge clk) begin
      if (mem_cen[i]) begin
        if (mem_wen) begin
          mem[mem_adr[i]] <= mem_wdt[i];
        end else begin
          rdt_q <= mem[mem_adr[i]];
        end
      end
    end

    assign mem_rdt[i] = rdt_q;
  end

endmodule: tcb_mem_bank

/* hw/tcb_mem_top.sv */
////////////////////////////////////////
// TCB byte-lane memory top level
// clear sequencer, lane controller, banks
////////////////////////////////////////

`timescale 1ns/100ps

module tcb_mem_top
  import tcb_pkg::*;
#(
  parameter int unsigned ADR_W = TCB_ADR_DEF,
  parameter int unsigned DAT_W = TCB_DAT_DEF
)(
  input  logic                        clk,
  input  logic                        rst_n,
  // request
  input  logic                        vld,
  input  logic                        wen,
  input  logic [ADR_W-1:0]            adr,
  input  logic [DAT_W/TCB_BYTE-1:0]   ben,
  input  logic [DAT_W-1:0]            wdt,
  // handshake and response
  output logic                        rdy,
  output logic                        rsp_vld,
  output logic [DAT_W-1:0]            rdt
);

  // lane geometry
  localparam int unsigned BEN   = DAT_W/TCB_BYTE;
  localparam int unsigned MEM_A = ADR_W-$clog2(BEN);

  ////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////

  // clear sweep
  logic                             clr_act;
  logic                             clr_last;
  logic [MEM_A-1:0]                 clr_adr;
  // lane SRAM bus
  logic [BEN-1:0]                   mem_cen;
  logic                             mem_wen;
  logic [BEN-1:0][MEM_A-1:0]        mem_adr;
  logic [BEN-1:0][TCB_BYTE-1:0]     mem_wdt;
  logic [BEN-1:0][TCB_BYTE-1:0]     mem_rdt;

  ////////////////////////////////////////
  // instances
  ////////////////////////////////////////

  tcb_mem_clear_fsm u_clear_fsm (
    .clk      (clk),
    .rst_n    (rst_n),
    .clr_last (clr_last),
    .clr_act  (clr_act),
    .rdy      (rdy)
  );

  tcb_mem_clear_counter #(
    .ADR_W (ADR_W),
    .DAT_W (DAT_W)
  ) u_clear_counter (
    .clk      (clk),
    .rst_n    (rst_n),
    .clr_act  (clr_act),
    .clr_adr  (clr_adr),
    .clr_last (clr_last)
  );

  // request side to lane SRAM side
  tcb_lib_misaligned_memory_controller #(
    .ADR_W (ADR_W),
    .DAT_W (DAT_W)
  ) u_controller (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .ben     (ben),
    .wdt     (wdt),
    .clr_act (clr_act),
    .clr_adr (clr_adr),
    .mem_cen (mem_cen),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt),
    .rsp_vld (rsp_vld),
    .rdt     (rdt)
  );

  tcb_mem_bank #(
    .ADR_W (ADR_W),
    .DAT_W (DAT_W)
  ) u_bank (
    .clk     (clk),
    .mem_cen (mem_cen),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt)
  );

endmodule: tcb_mem_top

/* testbench/tcb_mem_checker.sv */
////////////////////////////////////////
// TCB memory checker
// byte-array model and read compare
////////////////////////////////////////

`timescale 1ns/100ps

module tcb_mem_checker
  import tcb_pkg::*;
#(
  parameter int unsigned ADR_W = TCB_ADR_DEF,
  parameter int unsigned DAT_W = TCB_DAT_DEF
)(
  input  logic                      clk,
  input  logic                      rst_n,
  // DUT ports
  input  logic                      vld,
  input  logic                      wen,
  input  logic [ADR_W-1:0]          adr,
  input  logic [DAT_W/TCB_BYTE-1:0] ben,
  input  logic [DAT_W-1:0]          wdt,
  input  logic                      rdy,
  input  logic                      rsp_vld,
  input  logic [DAT_W-1:0]          rdt,
  // table expectation for the current request
  input  logic                      tab_chk,
  input  logic [DAT_W-1:0]          tab_exp,
  // read waiting for its response
  output logic                      busy,
  output int unsigned               err_cnt,
  output int unsigned               chk_cnt
);

  localparam int unsigned BEN   = DAT_W/TCB_BYTE;
  localparam int unsigned OFF_W = $clog2(BEN);
  // one clear cycle per word
  localparam int unsigned WORDS = 2**(ADR_W-OFF_W);

  // byte space model starting all zero
  logic [TCB_BYTE-1:0] mdl [2**ADR_W];
  // pending read
  logic [ADR_W-1:0]    adr_q;
  logic [DAT_W-1:0]    exp_q;
  logic [DAT_W-1:0]    msk_q;
  logic [DAT_W-1:0]    tab_q;
  logic                tab_use;
  // clear phase tracking
  logic                rdy_seen;
  int unsigned         clr_cyc;

  // lane i carries the byte whose low address bits equal i,
  // so it lands (i - off) mod lanes bytes above the access address
  function automatic logic [ADR_W-1:0] lane_byte(input logic [ADR_W-1:0] a, input int i);
    logic [OFF_W-1:0] rot;
    rot = OFF_W'(i) - a[OFF_W-1:0];
    return a + ADR_W'(rot);
  endfunction

  // only enabled lanes are read
  task automatic compare(input logic [DAT_W-1:0] exp);
    if ((rdt & msk_q) !== (exp & msk_q)) begin
      err_cnt++;
      $display("[ERROR] rdt at adr 0x%h: expected 0x%h, actual 0x%h",
               adr_q, exp & msk_q, rdt & msk_q);
    end
  endtask

  initial begin
    foreach (mdl[j]) mdl[j] = '0;
    busy     = 1'b0;
    err_cnt  = 0;
    chk_cnt  = 0;
    rdy_seen = 1'b0;
    clr_cyc  = 0;
  end

  ////////////////////////////////////////
  // sampled mid-cycle when inputs are stable
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      // clear lasts one cycle per word, then rdy holds
      if (rdy_seen && !rdy) begin
        err_cnt++;
        $display("rdy dropped low after the clear had finished");
      end else if (!rdy_seen && rdy && clr_cyc != WORDS) begin
        err_cnt++;
        $display("clear took %0d cycles instead of %0d", clr_cyc, WORDS);
      end
      if (!rdy) begin
        clr_cyc++;
      end
      rdy_seen = rdy_seen | rdy;
      // response for last cycle's read
      if (rsp_vld && !busy) begin
        err_cnt++;
        $display("unexpected rsp_vld without a read in the cycle before");
      end else if (!rsp_vld && busy) begin
        err_cnt++;
        $display("missing rsp_vld one cycle after the read at adr 0x%h", adr_q);
      end else if (busy) begin
        chk_cnt++;
        compare(exp_q);
        if (tab_use) begin
          compare(tab_q);
        end
      end
      busy = 1'b0;
      // request taken at the coming edge
      if (vld && rdy && wen) begin
        for (int i = 0; i < BEN; i++) begin
          if (ben[i]) begin
            mdl[lane_byte(adr, i)] = wdt[i*TCB_BYTE+:TCB_BYTE];
          end
        end
      end else if (vld && rdy) begin
        busy    = 1'b1;
        adr_q   = adr;
        tab_use = tab_chk;
        tab_q   = tab_exp;
        for (int i = 0; i < BEN; i++) begin
          exp_q[i*TCB_BYTE+:TCB_BYTE] = mdl[lane_byte(adr, i)];
          msk_q[i*TCB_BYTE+:TCB_BYTE] = {TCB_BYTE{ben[i]}};
        end
      end
    end
  end

endmodule: tcb_mem_checker

/* testbench/tcb_mem_tb.sv */
////////////////////////////////////////
// TCB byte-lane memory testbench
// request table, random burst, summary
////////////////////////////////////////

`timescale 1ns/100ps

module tcb_mem_tb
  import tcb_pkg::*;
();

  localparam int unsigned ADR_W     = TCB_ADR_DEF;
  localparam int unsigned DAT_W     = TCB_DAT_DEF;
  localparam int unsigned BEN       = DAT_W/TCB_BYTE;
  localparam int unsigned SEED      = 58481;
  localparam int unsigned HALF      = 20;
  localparam int unsigned RDY_LIMIT = 1000;
  localparam int unsigned RSP_LIMIT = 8;

  // one request and its expected read word
  typedef struct {
    int unsigned      tst;
    logic             wen;
    logic [ADR_W-1:0] adr;
    logic [BEN-1:0]   ben;
    logic [DAT_W-1:0] wdt;
    logic             chk;
    logic [DAT_W-1:0] exp;
  } req_t;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             vld;
  logic             wen;
  logic [ADR_W-1:0] adr;
  logic [BEN-1:0]   ben;
  logic [DAT_W-1:0] wdt;
  logic             rdy;
  logic             rsp_vld;
  logic [DAT_W-1:0] rdt;
  logic             tab_chk;
  logic [DAT_W-1:0] tab_exp;
  logic             busy;
  logic             tmo;
  int unsigned      err_cnt;
  int unsigned      chk_cnt;
  int unsigned      prev_err;
  int unsigned      n_test;
  req_t             tab[$];

  always #HALF clk = ~clk;

  tcb_mem_top #(.ADR_W(ADR_W), .DAT_W(DAT_W)) u_tcb_mem_top (
    .clk(clk), .rst_n(rst_n), .vld(vld), .wen(wen), .adr(adr), .ben(ben),
    .wdt(wdt), .rdy(rdy), .rsp_vld(rsp_vld), .rdt(rdt)
  );

  tcb_mem_checker #(.ADR_W(ADR_W), .DAT_W(DAT_W)) u_checker (
    .clk(clk), .rst_n(rst_n), .vld(vld), .wen(wen), .adr(adr), .ben(ben),
    .wdt(wdt), .rdy(rdy), .rsp_vld(rsp_vld), .rdt(rdt), .tab_chk(tab_chk),
    .tab_exp(tab_exp), .busy(busy), .err_cnt(err_cnt), .chk_cnt(chk_cnt)
  );

  task automatic add_req(input int unsigned t, input logic w, input logic [ADR_W-1:0] a,
                         input logic [BEN-1:0] b, input logic [DAT_W-1:0] d,
                         input logic c, input logic [DAT_W-1:0] e);
    tab.push_back('{t, w, a, b, d, c, e});
  endtask

  task automatic build_table();
    // zero after the clear, aligned, misaligned and wrapping
    add_req(1, 1'b0, 'h000, 4'hf, '0, 1'b1, 32'h0000_0000);
    add_req(1, 1'b0, 'h1a3, 4'hf, '0, 1'b1, 32'h0000_0000);
    add_req(1, 1'b0, 'h3fe, 4'hf, '0, 1'b1, 32'h0000_0000);
    // aligned word round trip
    add_req(2, 1'b1, 'h040, 4'hf, 32'h1122_3344, 1'b0, '0);
    add_req(2, 1'b0, 'h040, 4'hf, '0, 1'b1, 32'h1122_3344);
    // offset 1, lane 0 spills into word 0x21
    add_req(3, 1'b1, 'h081, 4'hf, 32'haabb_ccdd, 1'b0, '0);
    add_req(3, 1'b0, 'h080, 4'hf, '0, 1'b1, 32'haabb_cc00);
    add_req(3, 1'b0, 'h084, 4'hf, '0, 1'b1, 32'h0000_00dd);
    add_req(3, 1'b0, 'h081, 4'hf, '0, 1'b1, 32'haabb_ccdd);
    // partial enables keep the other bytes
    add_req(4, 1'b1, 'h040, 4'h5, 32'hffee_ddcc, 1'b0, '0);
    add_req(4, 1'b0, 'h040, 4'hf, '0, 1'b1, 32'h11ee_33cc);
    add_req(4, 1'b1, 'h082, 4'h8, 32'h5500_0000, 1'b0, '0);
    add_req(4, 1'b0, 'h080, 4'hf, '0, 1'b1, 32'h55bb_cc00);
    // top word, lanes 0 and 1 wrap to word 0
    add_req(5, 1'b1, 'h3fe, 4'hf, 32'h0102_0304, 1'b0, '0);
    add_req(5, 1'b0, 'h3fc, 4'hf, '0, 1'b1, 32'h0102_0000);
    add_req(5, 1'b0, 'h000, 4'hf, '0, 1'b1, 32'h0000_0304);
    // random writes, then a back-to-back read burst against the model
    repeat (12) add_req(6, 1'b1, ADR_W'($urandom), BEN'($urandom), $urandom, 1'b0, '0);
    repeat (16) add_req(6, 1'b0, ADR_W'($urandom), '1, '0, 1'b0, '0);
  endtask

  // rdy is stable mid-cycle, the edge after it takes the request
  task automatic wait_rdy();
    int unsigned cnt;
    cnt = 0;
    while (!rdy && cnt < RDY_LIMIT) begin
      @(posedge clk);
      #2;
      cnt++;
    end
    if (!rdy) begin
      $display("timeout: rdy stayed low for %0d cycles", cnt);
      tmo = 1'b1;
    end else begin
      @(posedge clk);
      #2;
    end
  endtask

  // drain the last response, then report the test
  task automatic end_test(input int unsigned t);
    int unsigned cnt;
    vld     = 1'b0;
    tab_chk = 1'b0;
    cnt     = 0;
    while (busy && cnt < RSP_LIMIT) begin
      @(posedge clk);
      #2;
      cnt++;
    end
    if (busy) begin
      $display("timeout: no read response at the end of test %0d", t);
      tmo = 1'b1;
    end
    $display("test %0d: %s, %0d errors", t, (err_cnt == prev_err) ? "ok" : "FAILED",
             err_cnt - prev_err);
    prev_err = err_cnt;
    n_test++;
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n    = 1'b0;
    vld      = 1'b0;
    wen      = 1'b0;
    adr      = '0;
    ben      = '0;
    wdt      = '0;
    tab_chk  = 1'b0;
    tab_exp  = '0;
    tmo      = 1'b0;
    prev_err = 0;
    n_test   = 0;
    build_table();
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int n = 0; n < tab.size(); n++) begin
      if (n > 0 && tab[n].tst != tab[n-1].tst) begin
        end_test(tab[n-1].tst);
      end
      if (tmo) begin
        break;
      end
      vld     = 1'b1;
      wen     = tab[n].wen;
      adr     = tab[n].adr;
      ben     = tab[n].ben;
      wdt     = tab[n].wdt;
      tab_chk = tab[n].chk;
      tab_exp = tab[n].exp;
      wait_rdy();
      if (tmo) begin
        break;
      end
    end
    if (!tmo) begin
      end_test(tab[tab.size()-1].tst);
    end
    $display("%0d tests, %0d reads checked, %0d errors", n_test, chk_cnt, err_cnt);
    if (err_cnt == 0 && !tmo) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule: tcb_mem_tb

/* list.f */
hw/tcb_pkg.sv
hw/tcb_mem_clear_fsm.sv
hw/tcb_mem_clear_counter.sv
hw/tcb_lib_misaligned_memory_controller.sv
hw/tcb_mem_bank.sv
hw/tcb_mem_top.sv
testbench/tcb_mem_checker.sv
testbench/tcb_mem_tb.sv

/* run.sh */
#!/bin/sh
# build and run the TCB memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tcb_mem_tb

out=$(./obj_dir/Vtcb_mem_tb)
echo "$out"

# pass only if the testbench printed the pass line
echo "$out" | grep -q "^Test completed successfully$"
